// ==== sources.f ====
rtl/io_pkg.sv
rtl/pad_attr_regs.sv
rtl/pad_cell.sv
rtl/jtag_overlay.sv
rtl/io_subsys_top.sv
verification/io_subsys_sva.sv
verification/tb_io_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the I/O subsystem simulation with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_io_subsys -f sources.f -o sim_io_subsys

./obj_dir/sim_io_subsys | tee sim.log

if grep -q "Done: errors found" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== verification/tb_io_subsys.sv ====
// I/O subsystem testbench
// Random pad, core and attribute stimulus checked against a cycle model

`timescale 1ns/100ps
`default_nettype none

module tb_io_subsys;

  import io_pkg::*;

  localparam int max_cycles  = 3000;  // Phases add up to about 2200
  localparam int drive_delay = 1;

  logic                 clk;
  logic                 rst;
  logic                 attr_we;
  logic [pad_idx_w-1:0] attr_addr;
  pad_attr_t            attr_wdata;
  pad_core_t            core_req;
  logic [num_pads-1:0]  core_in;
  jtag_t                jtag;
  logic                 jtag_tdo;
  logic                 jtag_active;
  logic [num_pads-1:0]  pad_in;
  logic [num_pads-1:0]  pad_ext;
  logic [num_pads-1:0]  pad_out;
  logic [num_pads-1:0]  pad_oe;

  integer    seed;
  int        errors;
  int        cycle_cnt;
  pad_attr_t model_attr [num_pads];
  logic [num_pads-1:0] sync1;  // Model of the first synchronizer stage
  logic [num_pads-1:0] sync2;

  io_subsys_top UUT (
    .clk_i         ( clk         ),
    .rst_i         ( rst         ),
    .attr_we_i     ( attr_we     ),
    .attr_addr_i   ( attr_addr   ),
    .attr_wdata_i  ( attr_wdata  ),
    .core_req_i    ( core_req    ),
    .core_in_o     ( core_in     ),
    .jtag_o        ( jtag        ),
    .jtag_tdo_i    ( jtag_tdo    ),
    .jtag_active_o ( jtag_active ),
    .pad_in_i      ( pad_in      ),
    .pad_ext_en_i  ( pad_ext     ),
    .pad_out_o     ( pad_out     ),
    .pad_oe_o      ( pad_oe      )
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("Run timed out after %0d cycles", cycle_cnt);
      $display("Errors: %0d", errors);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic is_jtag_pad(input int i);
    return (i == tck_idx) || (i == tms_idx) || (i == tdi_idx) ||
           (i == tdo_idx) || (i == trst_idx);
  endfunction

  task automatic report_mismatch(input string what, input logic [15:0] got,
                                 input logic [15:0] exp);
    $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  // Checks one cycle at the falling edge, then steps the model
  task automatic check_cycle();
    logic [num_pads-1:0] req_out, req_oe, exp_out, exp_oe, exp_in, lvl, in_raw;
    jtag_t exp_jtag;
    logic  active;
    @(negedge clk);
    active  = sync2[jtag_en_idx];
    req_out = core_req.out;
    req_oe  = core_req.oe;
    for (int i = 0; i < num_pads; i++) begin
      if (active && is_jtag_pad(i)) begin
        req_out[i] = (i == tdo_idx) ? jtag_tdo : 1'b0;
        req_oe[i]  = (i == tdo_idx);  // Only TDO is an output
      end
      exp_out[i] = req_out[i] ^ model_attr[i].invert;
      exp_oe[i]  = req_oe[i] && !(model_attr[i].open_drain && exp_out[i]);
      if (pad_ext[i]) begin
        lvl[i] = pad_in[i];
      end else if (exp_oe[i]) begin
        lvl[i] = exp_out[i];
      end else begin
        lvl[i] = model_attr[i].pull_en && model_attr[i].pull_up;
      end
      in_raw[i] = lvl[i] ^ model_attr[i].invert;
      // Core sees chip select high on TMS, zero on the rest
      exp_in[i] = (active && is_jtag_pad(i)) ? (i == tms_idx) : sync2[i];
    end
    exp_jtag = '0;
    if (active) begin
      exp_jtag.tck    = sync2[tck_idx];
      exp_jtag.tms    = sync2[tms_idx];
      exp_jtag.tdi    = sync2[tdi_idx];
      exp_jtag.trst_n = sync2[trst_idx];
    end
    if (pad_out !== exp_out) report_mismatch("pad_out_o", pad_out, exp_out);
    if (pad_oe !== exp_oe) report_mismatch("pad_oe_o", pad_oe, exp_oe);
    if (core_in !== exp_in) report_mismatch("core_in_o", core_in, exp_in);
    if (jtag !== exp_jtag) report_mismatch("jtag_o", 16'(jtag), 16'(exp_jtag));
    if (jtag_active !== active) begin
      report_mismatch("jtag_active_o", 16'(jtag_active), 16'(active));
    end
    sync2 = sync1;
    sync1 = in_raw;
    if (attr_we) model_attr[attr_addr] = attr_wdata;  // Visible next cycle
    @(posedge clk);
    #(drive_delay);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_inputs(input logic writes_on, input logic pins_on,
                              input logic strap, input logic keep_tdo);
    logic [31:0] r;
    r = $random(seed);
    core_req.out = r[15:0];
    core_req.oe  = r[31:16];
    r = $random(seed);
    jtag_tdo   = r[0];
    attr_we    = writes_on & r[1];
    attr_addr  = r[2 +: pad_idx_w];
    attr_wdata = r[9:6];
    if (int'(attr_addr) == jtag_en_idx) attr_we = 1'b0;  // Strap stays plain
    if (keep_tdo && int'(attr_addr) == tdo_idx) attr_wdata.open_drain = 1'b0;
    r = $random(seed);
    pad_in  = pins_on ? r[15:0] : '0;
    pad_ext = pins_on ? r[31:16] : '0;
    pad_in[jtag_en_idx]  = strap;
    pad_ext[jtag_en_idx] = 1'b1;
    if (keep_tdo) pad_ext[tdo_idx] = 1'b0;  // No contention on TDO
  endtask

  task automatic run_phase(input int cycles, input logic writes_on,
                           input logic pins_on, input logic strap,
                           input logic keep_tdo);
    repeat (cycles) begin
      drive_inputs(writes_on, pins_on, strap, keep_tdo);
      check_cycle();
    end
  endtask

  initial begin
    seed       = 11;
    errors     = 0;
    cycle_cnt  = 0;
    clk        = 1'b0;
    rst        = 1'b1;
    attr_we    = 1'b0;
    attr_addr  = '0;
    attr_wdata = '0;
    core_req   = '0;
    jtag_tdo   = 1'b0;
    pad_in     = '0;
    pad_ext    = '0;
    sync1      = '0;
    sync2      = '0;
    for (int i = 0; i < num_pads; i++) model_attr[i] = '0;
    repeat (2) @(posedge clk);
    #(drive_delay);
    rst = 1'b0;

    run_phase(200, 1'b0, 1'b0, 1'b0, 1'b0);  // Default attributes
    run_phase(400, 1'b1, 1'b0, 1'b0, 1'b0);  // Attribute writes, loopback
    run_phase(800, 1'b1, 1'b1, 1'b0, 1'b0);  // Pins, pulls, inversion

    // TDO pad back to push-pull before the overlay takes it
    drive_inputs(1'b0, 1'b1, 1'b0, 1'b0);
    attr_we    = 1'b1;
    attr_addr  = pad_idx_w'(tdo_idx);
    attr_wdata = '0;
    check_cycle();

    run_phase(600, 1'b1, 1'b1, 1'b1, 1'b1);  // JTAG overlay active
    run_phase(200, 1'b1, 1'b1, 1'b0, 1'b1);  // Strap low again

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/io_subsys_sva.sv ====
// I/O subsystem assertions
// Bound to the top level, checks reset, open drain and TDO drive

`timescale 1ns/100ps
`default_nettype none

module io_subsys_sva (
  input wire logic                                        clk_i,
  input wire logic                                        rst_i,
  input wire io_pkg::pad_attr_t [io_pkg::num_pads-1:0]    attr_i,
  input wire logic [io_pkg::num_pads-1:0]                 pad_out_i,
  input wire logic [io_pkg::num_pads-1:0]                 pad_oe_i,
  input wire logic                                        jtag_active_i
);

  import io_pkg::*;

  // Strap synchronizer comes out of reset cleared
  assert property (@(posedge clk_i) rst_i |=> !jtag_active_i)
    else $error("jtag_active_o high in the cycle after reset");

  for (genvar i = 0; i < num_pads; i++) begin : g_od
    assert property (@(posedge clk_i) disable iff (rst_i)
      attr_i[i].open_drain |-> !(pad_oe_i[i] && pad_out_i[i]))
      else $error("Open-drain pad %0d drives a high level", i);
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    jtag_active_i |-> pad_oe_i[tdo_idx])
    else $error("TDO pad not driven while JTAG is active");

endmodule

bind io_subsys_top io_subsys_sva u_sva (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .attr_i        ( pad_attr      ),
  .pad_out_i     ( pad_out_o     ),
  .pad_oe_i      ( pad_oe_o      ),
  .jtag_active_i ( jtag_active_o )
);

`default_nettype wire

// ==== rtl/io_subsys_top.sv ====
// I/O subsystem top level
// Attribute registers, sixteen pad cells and the JTAG overlay mux

`timescale 1ns/100ps
`default_nettype none

module io_subsys_top (
  input  wire logic                          clk_i,
  input  wire logic                          rst_i,
  // Attribute write strobe
  input  wire logic                          attr_we_i,
  input  wire logic [io_pkg::pad_idx_w-1:0]  attr_addr_i,
  input  wire io_pkg::pad_attr_t             attr_wdata_i,
  // Core side
  input  wire io_pkg::pad_core_t             core_req_i,
  output logic [io_pkg::num_pads-1:0]        core_in_o,
  // JTAG side
  output io_pkg::jtag_t                      jtag_o,
  input  wire logic                          jtag_tdo_i,
  output logic                               jtag_active_o,
  // Pin side
  input  wire logic [io_pkg::num_pads-1:0]   pad_in_i,
  input  wire logic [io_pkg::num_pads-1:0]   pad_ext_en_i,
  output logic [io_pkg::num_pads-1:0]        pad_out_o,
  output logic [io_pkg::num_pads-1:0]        pad_oe_o
);

  import io_pkg::*;

  pad_attr_t [num_pads-1:0] pad_attr;
  logic      [num_pads-1:0] cell_out;
  logic      [num_pads-1:0] cell_oe;
  logic      [num_pads-1:0] pad_sync;

  ////////////////////////////////////////////////////////////////////
  // Attribute registers
  ////////////////////////////////////////////////////////////////////

  pad_attr_regs u_attr_regs (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .attr_we_i    ( attr_we_i    ),
    .attr_addr_i  ( attr_addr_i  ),
    .attr_wdata_i ( attr_wdata_i ),
    .attr_o       ( pad_attr     )
  );

  ////////////////////////////////////////////////////////////////////
  // Pad cells
  ////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < num_pads; i++) begin : g_pad
    pad_cell u_pad_cell (
      .clk_i        ( clk_i           ),
      .rst_i        ( rst_i           ),
      .attr_i       ( pad_attr[i]     ),
      .out_i        ( cell_out[i]     ),
      .oe_i         ( cell_oe[i]      ),
      .in_o         ( pad_sync[i]     ),
      .pad_in_i     ( pad_in_i[i]     ),
      .pad_ext_en_i ( pad_ext_en_i[i] ),
      .pad_out_o    ( pad_out_o[i]    ),
      .pad_oe_o     ( pad_oe_o[i]     )
    );
  end

  ////////////////////////////////////////////////////////////////////
  // JTAG overlay
  ////////////////////////////////////////////////////////////////////

  jtag_overlay u_jtag_overlay (
    .core_req_i    ( core_req_i    ),
    .core_in_o     ( core_in_o     ),
    .pad_sync_i    ( pad_sync      ),  // Already two flops deep
    .cell_out_o    ( cell_out      ),
    .cell_oe_o     ( cell_oe       ),
    .jtag_tdo_i    ( jtag_tdo_i    ),
    .jtag_o        ( jtag_o        ),
    .jtag_active_o ( jtag_active_o )
  );

endmodule

`default_nettype wire

// ==== rtl/jtag_overlay.sv ====
// JTAG overlay mux
// Strap pad hands the JTAG pads to the JTAG port and ties off the core side

`timescale 1ns/100ps
`default_nettype none

module jtag_overlay (
  // Core side
  input  wire io_pkg::pad_core_t           core_req_i,
  output logic [io_pkg::num_pads-1:0]      core_in_o,
  // Pad cell side
  input  wire logic [io_pkg::num_pads-1:0] pad_sync_i,
  output logic [io_pkg::num_pads-1:0]      cell_out_o,
  output logic [io_pkg::num_pads-1:0]      cell_oe_o,
  // JTAG port
  input  wire logic                        jtag_tdo_i,
  output io_pkg::jtag_t                    jtag_o,
  output logic                             jtag_active_o
);

  import io_pkg::*;

  logic strap_active;

  ////////////////////////////////////////////////////////////////////
  // Strap decode
  ////////////////////////////////////////////////////////////////////

  // Strap already passed through the cell synchronizer
  assign strap_active  = pad_sync_i[jtag_en_idx];
  assign jtag_active_o = strap_active;

  ////////////////////////////////////////////////////////////////////
  // Output side toward the pad cells
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    cell_out_o = core_req_i.out;
    cell_oe_o  = core_req_i.oe;
    if (strap_active) begin
      // JTAG inputs are released
      cell_out_o[tck_idx]  = 1'b0;
      cell_oe_o[tck_idx]   = 1'b0;
      cell_out_o[tms_idx]  = 1'b0;
      cell_oe_o[tms_idx]   = 1'b0;
      cell_out_o[tdi_idx]  = 1'b0;
      cell_oe_o[tdi_idx]   = 1'b0;
      cell_out_o[trst_idx] = 1'b0;
      cell_oe_o[trst_idx]  = 1'b0;
      // TDO is always driven
      cell_out_o[tdo_idx]  = jtag_tdo_i;
      cell_oe_o[tdo_idx]   = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Input side toward the core and the JTAG port
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    core_in_o = pad_sync_i;
    jtag_o    = '0;  // Holds TAP in reset when inactive
    if (strap_active) begin
      core_in_o     = (pad_sync_i & ~jtag_pad_mask) | (tie_off_values & jtag_pad_mask);
      jtag_o.tck    = pad_sync_i[tck_idx];
      jtag_o.tms    = pad_sync_i[tms_idx];
      jtag_o.tdi    = pad_sync_i[tdi_idx];
      jtag_o.trst_n = pad_sync_i[trst_idx];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pad_cell.sv ====
// Single pad cell
// Applies invert, open drain and pull, then synchronizes the input

`timescale 1ns/100ps
`default_nettype none

module pad_cell (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire io_pkg::pad_attr_t attr_i,
  // Core side
  input  wire logic              out_i,
  input  wire logic              oe_i,
  output logic                   in_o,
  // Pin side
  input  wire logic              pad_in_i,
  input  wire logic              pad_ext_en_i,
  output logic                   pad_out_o,
  output logic                   pad_oe_o
);

  logic       drive_val;
  logic       pad_val;
  logic       in_raw;
  logic [1:0] sync_q;

  ////////////////////////////////////////////////////////////////////
  // Output path
  ////////////////////////////////////////////////////////////////////

  assign drive_val = out_i ^ attr_i.invert;
  assign pad_out_o = drive_val;

  // Open drain releases the pin instead of driving a one
  assign pad_oe_o = attr_i.open_drain ? (oe_i & ~drive_val) : oe_i;

  ////////////////////////////////////////////////////////////////////
  // Input path
  ////////////////////////////////////////////////////////////////////

  // Resolve the level on the pin
  always_comb begin
    if (pad_ext_en_i) begin
      pad_val = pad_in_i;  // Outside world wins
    end else if (pad_oe_o) begin
      pad_val = drive_val;  // Loopback
    end else begin
      pad_val = attr_i.pull_en & attr_i.pull_up;  // Pull or floating low
    end
  end

  assign in_raw = pad_val ^ attr_i.invert;

  // Two-flop synchronizer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], in_raw};
    end
  end

  assign in_o = sync_q[1];

endmodule

`default_nettype wire

// ==== rtl/pad_attr_regs.sv ====
// Pad attribute register bank
// One attribute word per pad, written by a single-cycle strobe

`timescale 1ns/100ps
`default_nettype none

module pad_attr_regs (
  input  wire logic                                       clk_i,
  input  wire logic                                       rst_i,
  // Write strobe
  input  wire logic                                       attr_we_i,
  input  wire logic [io_pkg::pad_idx_w-1:0]               attr_addr_i,
  input  wire io_pkg::pad_attr_t                          attr_wdata_i,
  // Attributes toward the pad cells
  output io_pkg::pad_attr_t [io_pkg::num_pads-1:0]        attr_o
);

  import io_pkg::*;

  pad_attr_t [num_pads-1:0] attr_q;
  logic      [num_pads-1:0] entry_we;

  ////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////

  // One-hot write enable per entry
  always_comb begin
    entry_we = '0;
    if (attr_we_i) begin
      entry_we[attr_addr_i] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////

  // Reset value means plain push-pull pad, no pull
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      attr_q <= '0;
    end else begin
      for (int i = 0; i < num_pads; i++) begin
        if (entry_we[i]) begin
          attr_q[i] <= attr_wdata_i;  // Visible next cycle
        end
      end
    end
  end

  assign attr_o = attr_q;

endmodule

`default_nettype wire

// ==== rtl/io_pkg.sv ====
// I/O subsystem package
// Pad counts, JTAG pad map, tie-off values and the shared pad structs

`default_nettype none

package io_pkg;

  ////////////////////////////////////////////////////////////////////
  // Pad counts and indices
  ////////////////////////////////////////////////////////////////////

  localparam int num_pads  = 16;
  localparam int pad_idx_w = $clog2(num_pads);  // 4 bits

  localparam int jtag_en_idx = 12;  // Strap pad, high selects JTAG
  localparam int tck_idx     = 8;
  localparam int tms_idx     = 9;   // Shared with an active-low chip select
  localparam int tdi_idx     = 10;
  localparam int tdo_idx     = 11;
  localparam int trst_idx    = 13;

  // Pads taken over while JTAG is active
  localparam logic [num_pads-1:0] jtag_pad_mask =
      (num_pads'(1'b1) << tck_idx) | (num_pads'(1'b1) << tms_idx) |
      (num_pads'(1'b1) << tdi_idx) | (num_pads'(1'b1) << tdo_idx) |
      (num_pads'(1'b1) << trst_idx);

  // Core sees chip select high (inactive) on the TMS pad
  localparam logic [num_pads-1:0] tie_off_values = num_pads'(1'b1) << tms_idx;

  ////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic invert;      // Flips out and in
    logic open_drain;  // Drive low only
    logic pull_en;
    logic pull_up;     // 1 = up, 0 = down
  } pad_attr_t;

  // Core drive request toward the pads
  typedef struct packed {
    logic [num_pads-1:0] out;
    logic [num_pads-1:0] oe;
  } pad_core_t;

  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic trst_n;
  } jtag_t;

endpackage

`default_nettype wire
